// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       := tb_mem_top
FILELIST  := mem_top.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := All checks passed

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram import mem_pkg::*; #(
  parameter int WORDS = RAM_WORDS
) (
  input  wire      clk,
  input  wire      reset_i,
  input  ram_req_t req_i,
  input  logic     we_i,
  output xlen_t    rdata_o
);

  localparam int IDX_W = $clog2(WORDS);

  xlen_t            mem [WORDS];
  xlen_t            rdata_q;
  logic [IDX_W-1:0] idx;

  // address wraps inside the array
  assign idx = req_i.word_addr[IDX_W-1:0];

  // byte lane writes
  always_ff @(posedge clk) begin
    if (we_i) begin
      for (int b = 0; b < 8; b++) begin
        if (req_i.wmask[b]) begin
          mem[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // registered read, one cycle after rd_en
  always_ff @(posedge clk) begin
    if (reset_i) begin
      rdata_q <= '0;
    end else if (req_i.rd_en) begin
      rdata_q <= mem[idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== hdl/lsu_format.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_format import mem_pkg::*; (
  // request side, from the incoming packet
  input  mem_op_e    mem_op_i,
  input  addr_t      addr_i,
  input  xlen_t      rs2_data_i,
  // response side, from the access slot
  input  xlen_t      rdata_i,
  input  mem_op_e    ram_op_i,
  input  logic [2:0] ram_offset_i,
  output ram_req_t   req_o,
  output logic       misaligned_o,
  output logic       is_load_o,
  output logic       is_store_o,
  output xlen_t      load_data_o
);

  logic [1:0] size_log2;
  byte_mask_t base_mask;
  logic [2:0] offset;
  xlen_t      lane;

  assign offset = addr_i[2:0];

  // access size as log2 of the byte count
  always_comb begin
    is_load_o  = 1'b0;
    is_store_o = 1'b0;
    size_log2  = 2'd0;
    case (mem_op_i)
      MEMOP_LB, MEMOP_LBU: is_load_o = 1'b1;
      MEMOP_LH, MEMOP_LHU: begin
        is_load_o = 1'b1;
        size_log2 = 2'd1;
      end
      MEMOP_LW, MEMOP_LWU: begin
        is_load_o = 1'b1;
        size_log2 = 2'd2;
      end
      MEMOP_LD: begin
        is_load_o = 1'b1;
        size_log2 = 2'd3;
      end
      MEMOP_SB: is_store_o = 1'b1;
      MEMOP_SH: begin
        is_store_o = 1'b1;
        size_log2  = 2'd1;
      end
      MEMOP_SW: begin
        is_store_o = 1'b1;
        size_log2  = 2'd2;
      end
      MEMOP_SD: begin
        is_store_o = 1'b1;
        size_log2  = 2'd3;
      end
      default: ;
    endcase
  end

  always_comb begin
    case (size_log2)
      2'd0:    base_mask = 8'b0000_0001;
      2'd1:    base_mask = 8'b0000_0011;
      2'd2:    base_mask = 8'b0000_1111;
      default: base_mask = 8'b1111_1111;
    endcase
  end

  // offset must be a multiple of the access size
  always_comb begin
    case (size_log2)
      2'd0:    misaligned_o = 1'b0;
      2'd1:    misaligned_o = offset[0];
      2'd2:    misaligned_o = |offset[1:0];
      default: misaligned_o = |offset;
    endcase
    misaligned_o = misaligned_o & (is_load_o | is_store_o);
  end

  assign req_o.word_addr = {3'b000, addr_i[ADDR_W-1:3]};
  assign req_o.wdata     = rs2_data_i << {offset, 3'b000};
  assign req_o.wmask     = is_store_o ? byte_mask_t'(base_mask << offset) : '0;
  assign req_o.rd_en     = is_load_o;

  // bring the addressed bytes down to lane 0
  assign lane = rdata_i >> {ram_offset_i, 3'b000};

  always_comb begin
    case (ram_op_i)
      MEMOP_LB:  load_data_o = {{56{lane[7]}}, lane[7:0]};
      MEMOP_LBU: load_data_o = {56'd0, lane[7:0]};
      MEMOP_LH:  load_data_o = {{48{lane[15]}}, lane[15:0]};
      MEMOP_LHU: load_data_o = {48'd0, lane[15:0]};
      MEMOP_LW:  load_data_o = {{32{lane[31]}}, lane[31:0]};
      MEMOP_LWU: load_data_o = {32'd0, lane[31:0]};
      MEMOP_LD:  load_data_o = lane;
      default:   load_data_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  localparam int XLEN        = 64;
  localparam int ADDR_W      = 64;
  localparam int RAM_WORDS   = 256;
  // queue entries, also the credits execute starts with
  localparam int QUEUE_DEPTH = 4;
  localparam int CREDIT_W    = 3;

  typedef logic [XLEN-1:0]     xlen_t;
  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [31:0]         inst_t;
  typedef logic [4:0]          reg_idx_t;
  typedef logic [7:0]          byte_mask_t;
  typedef logic [CREDIT_W-1:0] credit_t;

  typedef enum logic [3:0] {
    MEMOP_NONE = 4'd0,
    MEMOP_LB   = 4'd1,
    MEMOP_LBU  = 4'd2,
    MEMOP_LH   = 4'd3,
    MEMOP_LHU  = 4'd4,
    MEMOP_LW   = 4'd5,
    MEMOP_LWU  = 4'd6,
    MEMOP_LD   = 4'd7,
    MEMOP_SB   = 4'd8,
    MEMOP_SH   = 4'd9,
    MEMOP_SW   = 4'd10,
    MEMOP_SD   = 4'd11
  } mem_op_e;

  typedef enum logic [2:0] {
    TRAP_NONE             = 3'd0,
    TRAP_INHERITED        = 3'd1,
    TRAP_LOAD_MISALIGNED  = 3'd2,
    TRAP_STORE_MISALIGNED = 3'd3
  } trap_cause_e;

  // occupancy of the two mem_stage slots
  typedef enum logic [1:0] {
    SLOT_EMPTY  = 2'd0,
    SLOT_ACCESS = 2'd1,
    SLOT_DONE   = 2'd2
  } pipe_state_e;

  // packet from execute
  typedef struct packed {
    addr_t       pc;
    inst_t       inst;
    reg_idx_t    rd;
    mem_op_e     mem_op;
    xlen_t       alu_data;
    xlen_t       rs2_data;
    logic        trap_valid;
    trap_cause_e trap_cause;
  } ex_mem_t;

  // packet toward write-back
  typedef struct packed {
    addr_t       pc;
    inst_t       inst;
    reg_idx_t    rd;
    xlen_t       wb_data;
    logic        rd_write;
    trap_cause_e trap_cause;
    logic        trap_valid;
  } mem_wb_t;

  // word-granular RAM request, wdata and wmask already lane aligned
  typedef struct packed {
    addr_t      word_addr;
    xlen_t      wdata;
    byte_mask_t wmask;
    logic       rd_en;
  } ram_req_t;

endpackage

`default_nettype wire

// ==== hdl/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage import mem_pkg::*; (
  input  wire      clk,
  input  wire      reset_i,
  input  logic     ex_valid_i,
  input  ex_mem_t  ex_pkt_i,
  output ram_req_t ram_req_o,
  output logic     ram_we_o,
  input  xlen_t    ram_rdata_i,
  output logic     push_o,
  output mem_wb_t  push_pkt_o
);

  ram_req_t    fmt_req;
  logic        misaligned;
  logic        is_load;
  logic        is_store;
  xlen_t       load_data;
  logic        access_ok;
  logic        in_trap;
  trap_cause_e in_cause;

  // access slot
  pipe_state_e acc_state_q;
  ex_mem_t     acc_pkt_q;
  logic        acc_trap_q;
  trap_cause_e acc_cause_q;
  logic        acc_load_q;
  logic        acc_store_q;

  // done slot
  pipe_state_e done_state_q;
  mem_wb_t     done_pkt_q;
  mem_wb_t     wb_next;

  lsu_format u_lsu_format (
    .mem_op_i     (ex_pkt_i.mem_op),
    .addr_i       (ex_pkt_i.alu_data),
    .rs2_data_i   (ex_pkt_i.rs2_data),
    .rdata_i      (ram_rdata_i),
    .ram_op_i     (acc_pkt_q.mem_op),
    .ram_offset_i (acc_pkt_q.alu_data[2:0]),
    .req_o        (fmt_req),
    .misaligned_o (misaligned),
    .is_load_o    (is_load),
    .is_store_o   (is_store),
    .load_data_o  (load_data)
  );

  // an inherited trap takes priority over a new misalignment
  always_comb begin
    in_trap  = 1'b0;
    in_cause = TRAP_NONE;
    if (ex_pkt_i.trap_valid) begin
      in_trap  = 1'b1;
      in_cause = TRAP_INHERITED;
    end else if (misaligned) begin
      in_trap  = 1'b1;
      in_cause = is_load ? TRAP_LOAD_MISALIGNED : TRAP_STORE_MISALIGNED;
    end
  end

  assign access_ok = ex_valid_i & ~in_trap;

  // the RAM itself registers this on edge 1
  always_comb begin
    ram_req_o       = fmt_req;
    ram_req_o.rd_en = fmt_req.rd_en & access_ok;
  end

  assign ram_we_o = is_store & access_ok;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      acc_state_q  <= SLOT_EMPTY;
      done_state_q <= SLOT_EMPTY;
    end else begin
      acc_state_q  <= ex_valid_i ? SLOT_ACCESS : SLOT_EMPTY;
      done_state_q <= (acc_state_q == SLOT_ACCESS) ? SLOT_DONE : SLOT_EMPTY;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_i) begin
      acc_pkt_q   <= ex_pkt_i;
      acc_trap_q  <= in_trap;
      acc_cause_q <= in_cause;
      acc_load_q  <= is_load;
      acc_store_q <= is_store;
    end
  end

  // write-back data select; a trapped packet carries its faulting address
  always_comb begin
    wb_next.pc         = acc_pkt_q.pc;
    wb_next.inst       = acc_pkt_q.inst;
    wb_next.rd         = acc_pkt_q.rd;
    wb_next.trap_valid = acc_trap_q;
    wb_next.trap_cause = acc_cause_q;
    wb_next.rd_write   = ~acc_trap_q & ~acc_store_q;
    if (acc_trap_q) begin
      wb_next.wb_data = acc_pkt_q.alu_data;
    end else if (acc_load_q) begin
      wb_next.wb_data = load_data;
    end else if (acc_store_q) begin
      wb_next.wb_data = '0;
    end else begin
      wb_next.wb_data = acc_pkt_q.alu_data;
    end
  end

  always_ff @(posedge clk) begin
    if (acc_state_q == SLOT_ACCESS) begin
      done_pkt_q <= wb_next;
    end
  end

  assign push_o     = (done_state_q == SLOT_DONE);
  assign push_pkt_o = done_pkt_q;

endmodule

`default_nettype wire

// ==== hdl/mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_top import mem_pkg::*; (
  input  wire     clk,
  input  wire     reset_i,
  input  logic    ex_valid_i,
  input  ex_mem_t ex_pkt_i,
  output logic    ex_credit_o,
  input  logic    wb_credit_i,
  output logic    wb_valid_o,
  output mem_wb_t wb_pkt_o
);

  ram_req_t ram_req;
  logic     ram_we;
  xlen_t    ram_rdata;
  logic     push;
  mem_wb_t  push_pkt;

  mem_stage u_mem_stage (
    .clk         (clk),
    .reset_i     (reset_i),
    .ex_valid_i  (ex_valid_i),
    .ex_pkt_i    (ex_pkt_i),
    .ram_req_o   (ram_req),
    .ram_we_o    (ram_we),
    .ram_rdata_i (ram_rdata),
    .push_o      (push),
    .push_pkt_o  (push_pkt)
  );

  data_ram #(
    .WORDS (RAM_WORDS)
  ) u_data_ram (
    .clk     (clk),
    .reset_i (reset_i),
    .req_i   (ram_req),
    .we_i    (ram_we),
    .rdata_o (ram_rdata)
  );

  wb_queue u_wb_queue (
    .clk         (clk),
    .reset_i     (reset_i),
    .push_i      (push),
    .push_pkt_i  (push_pkt),
    .wb_credit_i (wb_credit_i),
    .wb_valid_o  (wb_valid_o),
    .wb_pkt_o    (wb_pkt_o),
    .ex_credit_o (ex_credit_o)
  );

endmodule

`default_nettype wire

// ==== hdl/wb_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_queue import mem_pkg::*; (
  input  wire     clk,
  input  wire     reset_i,
  input  logic    push_i,
  input  mem_wb_t push_pkt_i,
  input  logic    wb_credit_i,
  output logic    wb_valid_o,
  output mem_wb_t wb_pkt_o,
  output logic    ex_credit_o
);

  mem_wb_t                          entries [QUEUE_DEPTH];
  logic [$clog2(QUEUE_DEPTH)-1:0]   head_q;
  logic [$clog2(QUEUE_DEPTH)-1:0]   tail_q;
  credit_t                          count_q;
  credit_t                          credit_q;
  logic                             ex_credit_q;
  logic                             have_credit;
  logic                             send;

  // a credit arriving this cycle may be spent at once
  assign have_credit = (credit_q != '0) | wb_credit_i;
  assign send        = (count_q != '0) & have_credit;

  always_ff @(posedge clk) begin
    if (push_i) begin
      entries[tail_q] <= push_pkt_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      head_q      <= '0;
      tail_q      <= '0;
      count_q     <= '0;
      credit_q    <= '0;
      ex_credit_q <= 1'b0;
    end else begin
      if (push_i) begin
        tail_q <= tail_q + 1'b1;
      end
      if (send) begin
        head_q <= head_q + 1'b1;
      end
      case ({push_i, send})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
      case ({wb_credit_i, send})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: ;
      endcase
      // one upstream credit per packet gone
      ex_credit_q <= send;
    end
  end

  assign wb_valid_o  = send;
  assign wb_pkt_o    = entries[head_q];
  assign ex_credit_o = ex_credit_q;

endmodule

`default_nettype wire

// ==== mem_top.f ====
hdl/mem_pkg.sv
hdl/lsu_format.sv
hdl/data_ram.sv
hdl/mem_stage.sv
hdl/wb_queue.sv
hdl/mem_top.sv
tb/tb_mem_model.sv
tb/tb_mem_top.sv

// ==== tb/tb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model import mem_pkg::*; (
  input  wire     clk,
  input  logic    send_i,
  input  ex_mem_t send_pkt_i,
  input  logic    pop_i,
  output mem_wb_t exp_head_o,
  output int      exp_count_o
);

  // byte image of the address window the stimulus uses
  localparam int SHADOW_BYTES = 64;

  logic [7:0] shadow [SHADOW_BYTES];
  mem_wb_t    exp_q [$];

  function automatic int access_bytes(mem_op_e op);
    case (op)
      MEMOP_LB, MEMOP_LBU, MEMOP_SB: return 1;
      MEMOP_LH, MEMOP_LHU, MEMOP_SH: return 2;
      MEMOP_LW, MEMOP_LWU, MEMOP_SW: return 4;
      MEMOP_LD, MEMOP_SD:            return 8;
      default:                       return 0;
    endcase
  endfunction

  function automatic logic writes_memory(mem_op_e op);
    return op inside {MEMOP_SB, MEMOP_SH, MEMOP_SW, MEMOP_SD};
  endfunction

  function automatic logic sign_extends(mem_op_e op);
    return op inside {MEMOP_LB, MEMOP_LH, MEMOP_LW};
  endfunction

  always @(posedge clk) begin : update
    mem_wb_t     want;
    int          size;
    int          base;
    logic        store;
    logic [63:0] raw;
    if (pop_i && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
    end
    if (send_i) begin
      size            = access_bytes(send_pkt_i.mem_op);
      store           = writes_memory(send_pkt_i.mem_op);
      base            = int'(send_pkt_i.alu_data[5:0]);
      want.pc         = send_pkt_i.pc;
      want.inst       = send_pkt_i.inst;
      want.rd         = send_pkt_i.rd;
      want.trap_valid = 1'b0;
      want.trap_cause = TRAP_NONE;
      want.rd_write   = ~store;
      want.wb_data    = send_pkt_i.alu_data;
      if (send_pkt_i.trap_valid) begin
        want.trap_valid = 1'b1;
        want.trap_cause = TRAP_INHERITED;
        want.rd_write   = 1'b0;
      end else if (size != 0 && base % size != 0) begin
        want.trap_valid = 1'b1;
        want.trap_cause = store ? TRAP_STORE_MISALIGNED : TRAP_LOAD_MISALIGNED;
        want.rd_write   = 1'b0;
      end else if (store) begin
        for (int b = 0; b < size; b++) begin
          shadow[base + b] = send_pkt_i.rs2_data[8*b +: 8];
        end
        want.wb_data = '0;
      end else if (size != 0) begin
        raw = '0;
        // bytes above the access size copy the top bit for signed loads
        for (int b = 0; b < 8; b++) begin
          if (b < size) begin
            raw[8*b +: 8] = shadow[base + b];
          end else if (sign_extends(send_pkt_i.mem_op)) begin
            raw[8*b +: 8] = {8{raw[8*size-1]}};
          end
        end
        want.wb_data = raw;
      end
      exp_q.push_back(want);
    end
    if (exp_q.size() != 0) begin
      exp_head_o = exp_q[0];
    end else begin
      exp_head_o = '0;
    end
    exp_count_o = exp_q.size();
  end

endmodule

`default_nettype wire

// ==== tb/tb_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_top import mem_pkg::*; ();

  localparam int RESET_CYCLES   = 4;
  localparam int INIT_WORDS     = 8;
  localparam int RANDOM_PACKETS = 2000;
  localparam int TOTAL_PACKETS  = INIT_WORDS + RANDOM_PACKETS;
  localparam int TIMEOUT_CYCLES = 8 * TOTAL_PACKETS;

  logic    clk = 1'b0;
  logic    reset_i;
  logic    ex_valid;
  ex_mem_t ex_pkt;
  logic    ex_credit;
  logic    wb_credit;
  logic    wb_valid;
  mem_wb_t wb_pkt;
  logic    model_pop;
  mem_wb_t exp_head;
  int      exp_count;

  logic [31:0] lfsr_q = 32'heb0793ad;
  logic [5:0]  last_addr = '0;
  logic        timed_out = 1'b0;
  int          sent = 0;
  int          returned = 0;
  int          wb_seen = 0;
  int          granted = 0;
  int          cycles = 0;
  int          value_errors = 0;
  int          protocol_errors = 0;

  always #5 clk = ~clk;

  mem_top dut0 (
    .clk         (clk),
    .reset_i     (reset_i),
    .ex_valid_i  (ex_valid),
    .ex_pkt_i    (ex_pkt),
    .ex_credit_o (ex_credit),
    .wb_credit_i (wb_credit),
    .wb_valid_o  (wb_valid),
    .wb_pkt_o    (wb_pkt)
  );

  tb_mem_model model0 (
    .clk         (clk),
    .send_i      (ex_valid),
    .send_pkt_i  (ex_pkt),
    .pop_i       (model_pop),
    .exp_head_o  (exp_head),
    .exp_count_o (exp_count)
  );

  // right shifting Galois form, taps 32 31 29 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hd0000001;
    end
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[62:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  function automatic logic [5:0] align_mask(mem_op_e op);
    case (op)
      MEMOP_LH, MEMOP_LHU, MEMOP_SH: return 6'b111110;
      MEMOP_LW, MEMOP_LWU, MEMOP_SW: return 6'b111100;
      MEMOP_LD, MEMOP_SD:            return 6'b111000;
      default:                       return 6'b111111;
    endcase
  endfunction

  task automatic check_wb_pkt(input mem_wb_t got, input mem_wb_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("CHECK FAILED at %0t ns: wb pkt pc %h data %h rd_write %b trap %b cause %0d",
               $time, got.pc, got.wb_data, got.rd_write, got.trap_valid, got.trap_cause);
      $display("  expected pc %h data %h rd_write %b trap %b cause %0d",
               exp.pc, exp.wb_data, exp.rd_write, exp.trap_valid, exp.trap_cause);
    end
  endtask

  task automatic check_credit(input credit_t got, input credit_t exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_quiet(input string when);
    if (wb_valid !== 1'b0 || ex_credit !== 1'b0) begin
      protocol_errors++;
      $display("wb_valid_o or ex_credit_o not low %s at %0t ns", when, $time);
    end
  endtask

  task automatic make_packet(output ex_mem_t p);
    logic [63:0] r;
    logic [5:0]  addr;
    p = '0;
    take_bits(32, r);
    p.pc = {32'd0, r[31:2], 2'b00};
    take_bits(32, r);
    p.inst = r[31:0];
    take_bits(5, r);
    p.rd = r[4:0];
    take_bits(64, r);
    p.rs2_data = r;
    if (sent < INIT_WORDS) begin
      // known contents in the whole window before any load
      p.mem_op   = MEMOP_SD;
      p.alu_data = xlen_t'(sent * 8);
    end else begin
      take_bits(4, r);
      p.mem_op = (r[3:0] > 4'd11) ? MEMOP_NONE : mem_op_e'(r[3:0]);
      take_bits(2, r);
      if (r[1:0] == 2'd0) begin
        addr = last_addr;
      end else begin
        take_bits(6, r);
        addr = r[5:0];
      end
      // mostly aligned, the rest lands on any offset
      take_bits(2, r);
      if (r[1:0] != 2'd0) begin
        addr = addr & align_mask(p.mem_op);
      end
      if (p.mem_op == MEMOP_NONE) begin
        take_bits(64, r);
        p.alu_data = r;
      end else begin
        p.alu_data = {58'd0, addr};
        last_addr  = addr;
      end
      take_bits(4, r);
      if (r[3:0] == 4'd0) begin
        p.trap_valid = 1'b1;
        p.trap_cause = TRAP_INHERITED;
      end
    end
  endtask

  // outputs here reflect the inputs just driven on this falling edge
  task automatic sample_outputs();
    credit_t expect_outstanding;
    expect_outstanding = credit_t'(sent - wb_seen);
    if ($isunknown(wb_valid) || $isunknown(ex_credit)) begin
      protocol_errors++;
      $display("wb_valid_o or ex_credit_o unknown at %0t ns", $time);
    end
    if (ex_credit === 1'b1) begin
      returned++;
    end
    check_credit(credit_t'(sent - returned), expect_outstanding, "outstanding packets");
    if (returned > wb_seen) begin
      protocol_errors++;
      $display("upstream credit returned with no packet gone to write-back at %0t ns", $time);
    end
    model_pop = 1'b0;
    if (wb_valid === 1'b1) begin
      if (wb_seen >= granted) begin
        protocol_errors++;
        $display("wb_valid_o asserted without a write-back credit at %0t ns", $time);
      end
      if (exp_count == 0) begin
        protocol_errors++;
        $display("write-back packet with nothing outstanding at %0t ns", $time);
      end else begin
        check_wb_pkt(wb_pkt, exp_head);
        model_pop = 1'b1;
      end
      wb_seen++;
    end
  endtask

  task automatic drive_inputs();
    logic [63:0] r;
    ex_mem_t     p;
    logic        grant;
    ex_valid = 1'b0;
    if (sent < TOTAL_PACKETS && sent - returned < QUEUE_DEPTH) begin
      take_bits(2, r);
      if (sent < INIT_WORDS || r[1:0] != 2'd0) begin
        make_packet(p);
        ex_pkt   = p;
        ex_valid = 1'b1;
        sent++;
      end
    end
    // write-back alternates between a fast and a slow phase
    take_bits(2, r);
    if ((sent / 250) % 2 == 0) begin
      grant = (r[1:0] != 2'd0);
    end else begin
      grant = (r[1:0] == 2'd0);
    end
    wb_credit = grant && (granted - wb_seen < QUEUE_DEPTH);
    if (wb_credit) begin
      granted++;
    end
  endtask

  initial begin
    reset_i   = 1'b1;
    ex_valid  = 1'b0;
    ex_pkt    = '0;
    wb_credit = 1'b0;
    model_pop = 1'b0;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_quiet("during reset");
    end
    reset_i = 1'b0;
    repeat (2) begin
      @(negedge clk);
      check_quiet("right after reset");
    end

    while (wb_seen < TOTAL_PACKETS && !timed_out) begin
      @(negedge clk);
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        timed_out = 1'b1;
        protocol_errors++;
        ex_valid  = 1'b0;
        wb_credit = 1'b0;
        model_pop = 1'b0;
        $display("timeout: %0d of %0d packets came out within %0d cycles",
                 wb_seen, TOTAL_PACKETS, TIMEOUT_CYCLES);
      end else begin
        drive_inputs();
        // send depends on the credit driven just now
        #1;
        sample_outputs();
      end
    end

    // one more edge picks up the last upstream credit
    @(negedge clk);
    ex_valid  = 1'b0;
    wb_credit = 1'b0;
    #1;
    sample_outputs();
    if (!timed_out) begin
      check_credit(credit_t'(QUEUE_DEPTH - (sent - returned)), credit_t'(QUEUE_DEPTH),
                   "upstream credits at end");
      if (exp_count != 0) begin
        protocol_errors++;
        $display("%0d expected packets never came out", exp_count);
      end
    end

    $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
